// ==== logic/icache_consts.svh ====
////////////////////////////////////////////////////////////
// cache geometry and fetch widths
// line size, set count and way count must stay powers of two
// addresses with the uncached bit set never allocate a line
////////////////////////////////////////////////////////////

`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// associativity and sets
`define ICACHE_WAYS        4
`define ICACHE_WAY_BITS    2
`define ICACHE_SETS        16
`define ICACHE_INDEX_BITS  4
// byte offset inside a 16 byte line
`define ICACHE_OFFSET_BITS 4

// address split is tag | index | offset
`define ICACHE_ADDR_WIDTH  32
`define ICACHE_TAG_WIDTH   24
`define ICACHE_LINE_WIDTH  128
`define ICACHE_FETCH_WIDTH 32
// upper half of the address space bypasses the cache
`define ICACHE_NC_BIT      31
`define ICACHE_LFSR_WIDTH  8

`endif

// ==== logic/icache_pkg.sv ====
////////////////////////////////////////////////////////////
// shared vector types and the controller state encoding
// widths follow the geometry macros of the constants header
////////////////////////////////////////////////////////////

`include "icache_consts.svh"

package icache_pkg;

  // physical fetch address and its fields
  typedef logic [`ICACHE_ADDR_WIDTH-1:0]    addr_t;
  typedef logic [`ICACHE_TAG_WIDTH-1:0]     tag_t;
  typedef logic [`ICACHE_INDEX_BITS-1:0]    set_idx_t;
  // 32 bit word position inside the line
  typedef logic [`ICACHE_OFFSET_BITS-3:0]   word_sel_t;

  // payload
  typedef logic [`ICACHE_LINE_WIDTH-1:0]    line_t;
  typedef logic [`ICACHE_FETCH_WIDTH-1:0]   fetch_word_t;

  // way numbering, binary and one-hot
  typedef logic [`ICACHE_WAY_BITS-1:0]      way_idx_t;
  typedef logic [`ICACHE_WAYS-1:0]          way_mask_t;

  // controller FSM, FLUSH is the reset state
  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} ctrl_state_e;

endpackage

// ==== logic/icache_ctrl.sv ====
////////////////////////////////////////////////////////////
// cache controller, one fetch in flight at a time
// enabling the cache always passes through a full flush
// uncached and disabled fetches reuse the miss path
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 en_i,
  input  logic                 flush_i,
  input  logic                 req_i,
  input  icache_pkg::addr_t    addr_i,
  output logic                 ready_o,
  output logic                 valid_o,
  output logic                 miss_o,
  output logic                 busy_o,
  input  logic                 hit_i,
  output logic                 rd_en_o,
  output logic                 fill_o,
  output logic                 clear_o,
  output icache_pkg::set_idx_t index_o,
  output icache_pkg::tag_t     tag_o,
  output icache_pkg::word_sel_t word_sel_o,
  output logic                 compare_o,
  output logic                 mem_req_o,
  input  logic                 mem_ack_i,
  output icache_pkg::addr_t    mem_addr_o,
  output logic                 mem_nc_o,
  input  logic                 mem_rtrn_vld_i
);
  import icache_pkg::*;

  ctrl_state_e state_d, state_q;
  logic        cache_en_d, cache_en_q;
  logic        flush_d, flush_q;
  set_idx_t    flush_cnt_q;
  logic        flush_done;
  logic        can_accept;
  logic        accept;
  logic        addr_nc;
  logic        cmp_q;
  logic        nc_q;
  addr_t       addr_q;

  // a flush pulse is held until the FSM goes to FLUSH
  assign flush_d    = flush_q | flush_i;
  assign flush_done = (flush_cnt_q == set_idx_t'(`ICACHE_SETS - 1));
  // no new fetch while a flush or an enable is pending
  assign can_accept = ~flush_d & ~(en_i & ~cache_en_q);

  // ready in IDLE, and on a hit so hits can stream
  assign ready_o = can_accept & ((state_q == IDLE) | ((state_q == READ) & hit_i));
  assign accept  = ready_o & req_i;
  assign busy_o  = (state_q != IDLE);
  assign rd_en_o = accept;

  // disabled cache treats every address as uncached
  assign addr_nc = ~cache_en_q | addr_i[`ICACHE_NC_BIT];

  ////////////////////////////////////////////////////////////
  // array and way select commands
  ////////////////////////////////////////////////////////////

  // flush walks the sets, a new fetch reads its own set at once
  assign index_o = (state_q == FLUSH) ? flush_cnt_q :
                   accept ? addr_i[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS] :
                   addr_q[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
  assign tag_o      = addr_q[`ICACHE_ADDR_WIDTH-1 -: `ICACHE_TAG_WIDTH];
  assign word_sel_o = addr_q[`ICACHE_OFFSET_BITS-1:2];
  assign compare_o  = cmp_q;

  // full line for refills, single word for uncached reads
  assign mem_addr_o = nc_q ? {addr_q[`ICACHE_ADDR_WIDTH-1:2], 2'b00} :
                      {addr_q[`ICACHE_ADDR_WIDTH-1:`ICACHE_OFFSET_BITS],
                       {`ICACHE_OFFSET_BITS{1'b0}}};
  assign mem_nc_o   = nc_q;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d    = state_q;
    // turning off is immediate, turning on goes via FLUSH
    cache_en_d = cache_en_q & en_i;
    valid_o    = 1'b0;
    miss_o     = 1'b0;
    mem_req_o  = 1'b0;
    fill_o     = 1'b0;
    clear_o    = 1'b0;
    unique case (state_q)
      FLUSH: begin
        clear_o = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        if (!can_accept) begin
          state_d = FLUSH;
        end else if (accept) begin
          state_d = READ;
        end
      end
      READ: begin
        if (hit_i) begin
          valid_o = 1'b1;
          state_d = accept ? READ : IDLE;
        end else begin
          // miss or uncached, hold the request until acked
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~nc_q;
            state_d = MISS;
          end
        end
      end
      MISS: begin
        // return is consumed unconditionally
        if (mem_rtrn_vld_i) begin
          valid_o = 1'b1;
          fill_o  = ~nc_q;
          state_d = IDLE;
        end
      end
      default: state_d = FLUSH;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      cmp_q       <= 1'b0;
      nc_q        <= 1'b0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      // pending flush drops once the FSM leaves IDLE for FLUSH
      flush_q    <= ((state_q == IDLE) && !can_accept) ? 1'b0 : flush_d;
      if (state_q == FLUSH) begin
        flush_cnt_q <= flush_done ? '0 : flush_cnt_q + 1'b1;
      end
      // tag compare only for cacheable fetches
      cmp_q <= accept & ~addr_nc;
      if (accept) begin
        nc_q <= addr_nc;
      end
    end
  end

  // fetch address latch
  always_ff @(posedge clk_i) begin : p_addr
    if (accept) begin
      addr_q <= addr_i;
    end
  end

endmodule

// ==== logic/icache_way_select.sv ====
////////////////////////////////////////////////////////////
// tag compare, word select and replacement choice
// lowest hitting way wins if a tag is present twice
// victim is captured in the compare cycle only
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_way_select (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  icache_pkg::tag_t                            tag_i,
  input  icache_pkg::word_sel_t                       word_sel_i,
  input  logic                                        compare_i,
  input  logic                                        fill_i,
  input  icache_pkg::tag_t  [`ICACHE_WAYS-1:0]        tag_rdata_i,
  input  icache_pkg::way_mask_t                       valid_rdata_i,
  input  icache_pkg::line_t [`ICACHE_WAYS-1:0]        line_rdata_i,
  input  icache_pkg::line_t                           mem_rtrn_data_i,
  output logic                                        hit_o,
  output icache_pkg::fetch_word_t                     data_o,
  output icache_pkg::way_mask_t                       victim_o
);
  import icache_pkg::*;

  way_mask_t                        way_hit;
  way_idx_t                         hit_way;
  fetch_word_t [`ICACHE_WAYS-1:0]   way_word;
  fetch_word_t                      rtrn_word;
  way_idx_t                         inv_way;
  way_idx_t                         repl_way;
  logic                             all_valid;
  logic                             rnd_used_q;
  way_mask_t                        victim_q;
  logic [`ICACHE_LFSR_WIDTH-1:0]    lfsr_q;

  ////////////////////////////////////////////////////////////
  // hit detection and word select
  ////////////////////////////////////////////////////////////

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gen_cmp
    assign way_hit[w]  = valid_rdata_i[w] & (tag_rdata_i[w] == tag_i);
    assign way_word[w] = line_rdata_i[w][word_sel_i*`ICACHE_FETCH_WIDTH +: `ICACHE_FETCH_WIDTH];
  end

  // uncached words arrive in their own lane, same select applies
  assign rtrn_word = mem_rtrn_data_i[word_sel_i*`ICACHE_FETCH_WIDTH +: `ICACHE_FETCH_WIDTH];

  // priority to the lowest way
  always_comb begin : p_hit_way
    hit_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        hit_way = way_idx_t'(w);
      end
    end
  end

  assign hit_o  = compare_i & (|way_hit);
  assign data_o = compare_i ? way_word[hit_way] : rtrn_word;

  ////////////////////////////////////////////////////////////
  // replacement
  ////////////////////////////////////////////////////////////

  // first free way, else fall back to the LFSR
  always_comb begin : p_inv_way
    inv_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_rdata_i[w]) begin
        inv_way = way_idx_t'(w);
      end
    end
  end

  assign all_valid = &valid_rdata_i;
  assign repl_way  = all_valid ? lfsr_q[`ICACHE_WAY_BITS-1:0] : inv_way;
  assign victim_o  = victim_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_repl
    if (!rst_ni) begin
      victim_q   <= '0;
      rnd_used_q <= 1'b0;
      lfsr_q     <= 8'h5b;
    end else begin
      if (compare_i) begin
        victim_q   <= way_mask_t'(1) << repl_way;
        rnd_used_q <= all_valid;
      end
      // taps 8,6,5,4, only moves when a random victim was filled
      if (fill_i && rnd_used_q) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      end
    end
  end

endmodule

// ==== logic/icache_arrays.sv ====
////////////////////////////////////////////////////////////
// tag, valid and line storage per way
// reads appear one cycle after rd_en, writes land at the edge
// only the valid bits are reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_arrays (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  rd_en_i,
  input  logic                                  fill_i,
  input  logic                                  clear_i,
  input  icache_pkg::set_idx_t                  index_i,
  input  icache_pkg::way_mask_t                 way_i,
  input  icache_pkg::tag_t                      tag_i,
  input  icache_pkg::line_t                     line_i,
  output icache_pkg::tag_t  [`ICACHE_WAYS-1:0]  tag_rdata_o,
  output icache_pkg::way_mask_t                 valid_rdata_o,
  output icache_pkg::line_t [`ICACHE_WAYS-1:0]  line_rdata_o
);
  import icache_pkg::*;

  tag_t      tag_mem  [`ICACHE_WAYS][`ICACHE_SETS];
  line_t     line_mem [`ICACHE_WAYS][`ICACHE_SETS];
  // one bit per way for every set
  way_mask_t valid_q  [`ICACHE_SETS];

  ////////////////////////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        valid_q[s] <= '0;
      end
      valid_rdata_o <= '0;
    end else begin
      // clear drops every way of the set
      if (clear_i) begin
        valid_q[index_i] <= '0;
      end else if (fill_i) begin
        valid_q[index_i] <= valid_q[index_i] | way_i;
      end
      if (rd_en_i) begin
        valid_rdata_o <= valid_q[index_i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // tags and lines
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin : p_storage
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      // refill goes to the one-hot victim way
      if (fill_i && way_i[w]) begin
        tag_mem[w][index_i]  <= tag_i;
        line_mem[w][index_i] <= line_i;
      end
      if (rd_en_i) begin
        tag_rdata_o[w]  <= tag_mem[w][index_i];
        line_rdata_o[w] <= line_mem[w][index_i];
      end
    end
  end

endmodule

// ==== logic/icache_top.sv ====
////////////////////////////////////////////////////////////
// instruction cache top level
// memory must return a full line in one beat, consumed always
// uncached words come back in the lane of their address
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    en_i,
  input  logic                    flush_i,
  input  logic                    req_i,
  input  icache_pkg::addr_t       addr_i,
  output logic                    ready_o,
  output logic                    valid_o,
  output icache_pkg::fetch_word_t data_o,
  output logic                    miss_o,
  output logic                    busy_o,
  output logic                    mem_req_o,
  input  logic                    mem_ack_i,
  output icache_pkg::addr_t       mem_addr_o,
  output logic                    mem_nc_o,
  input  logic                    mem_rtrn_vld_i,
  input  icache_pkg::line_t       mem_rtrn_data_i
);
  import icache_pkg::*;

  // controller commands
  logic      hit;
  logic      rd_en;
  logic      fill;
  logic      clear;
  logic      compare;
  set_idx_t  index;
  tag_t      tag;
  word_sel_t word_sel;
  // array read data and victim
  tag_t  [`ICACHE_WAYS-1:0] tag_rdata;
  line_t [`ICACHE_WAYS-1:0] line_rdata;
  way_mask_t                valid_rdata;
  way_mask_t                victim;

  icache_ctrl icache_ctrl_inst (
    .clk_i, .rst_ni, .en_i, .flush_i, .req_i, .addr_i,
    .ready_o, .valid_o, .miss_o, .busy_o,
    .hit_i      (hit),
    .rd_en_o    (rd_en),
    .fill_o     (fill),
    .clear_o    (clear),
    .index_o    (index),
    .tag_o      (tag),
    .word_sel_o (word_sel),
    .compare_o  (compare),
    .mem_req_o, .mem_ack_i, .mem_addr_o, .mem_nc_o, .mem_rtrn_vld_i
  );

  icache_way_select icache_way_select_inst (
    .clk_i, .rst_ni,
    .tag_i           (tag),
    .word_sel_i      (word_sel),
    .compare_i       (compare),
    .fill_i          (fill),
    .tag_rdata_i     (tag_rdata),
    .valid_rdata_i   (valid_rdata),
    .line_rdata_i    (line_rdata),
    .mem_rtrn_data_i,
    .hit_o           (hit),
    .data_o,
    .victim_o        (victim)
  );

  icache_arrays icache_arrays_inst (
    .clk_i, .rst_ni,
    .rd_en_i       (rd_en),
    .fill_i        (fill),
    .clear_i       (clear),
    .index_i       (index),
    .way_i         (victim),
    .tag_i         (tag),
    .line_i        (mem_rtrn_data_i),
    .tag_rdata_o   (tag_rdata),
    .valid_rdata_o (valid_rdata),
    .line_rdata_o  (line_rdata)
  );

endmodule

// ==== dv/icache_tb.sv ====
////////////////////////////////////////////////////////////
// directed testbench for the instruction cache
// memory model answers each request with one full line
// every memory word is its own word address xor 5a5a0000
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tb;
  import icache_pkg::*;

  // roughly twenty times the length of the directed sequence
  localparam int    MAX_CYCLES = 4000;
  localparam addr_t LINE_A     = 32'h0000_1230;
  localparam addr_t UNC_ADDR   = 32'h8000_0a3a;

  logic        clk_i;
  logic        rst_ni;
  logic        en_i, flush_i, req_i;
  addr_t       addr_i;
  logic        ready_o, valid_o, miss_o, busy_o;
  fetch_word_t data_o;
  logic        mem_req_o, mem_ack_i, mem_nc_o, mem_rtrn_vld_i;
  addr_t       mem_addr_o;
  line_t       mem_rtrn_data_i;

  int          error_count;
  logic [31:0] lcg_state;
  // memory model bookkeeping captured at the ack
  int          mem_req_count;
  addr_t       mem_last_addr;
  logic        mem_last_nc;
  // outcome of the last single fetch
  int          last_lat;
  int          last_misses;
  int          last_reqs;
  logic        last_from_mem;

  icache_top icache_top_inst (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic fetch_word_t expected_word(addr_t a);
    return {a[31:2], 2'b00} ^ 32'h5a5a0000;
  endfunction

  // whole line around an address with word i in lane i
  function automatic line_t line_for(addr_t a);
    line_t l;
    for (int i = 0; i < 4; i++) begin
      l[i*`ICACHE_FETCH_WIDTH +: `ICACHE_FETCH_WIDTH] =
        expected_word({a[31:4], 4'h0} + addr_t'(4 * i));
    end
    return l;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_word(fetch_word_t got, fetch_word_t exp, string what);
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(addr_t got, addr_t exp, string what);
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////

  // ack after 0..2 cycles and return after 2..0 more
  initial begin : memory_model
    int delay;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_data_i = '0;
    mem_req_count   = 0;
    forever begin
      @(negedge clk_i);
      mem_ack_i      = 1'b0;
      mem_rtrn_vld_i = 1'b0;
      if (mem_req_o === 1'b1) begin
        delay = mem_req_count % 3;
        repeat (delay) @(negedge clk_i);
        mem_last_addr = mem_addr_o;
        mem_last_nc   = mem_nc_o;
        mem_req_count++;
        mem_ack_i = 1'b1;
        @(negedge clk_i);
        mem_ack_i = 1'b0;
        repeat (2 - delay) @(negedge clk_i);
        mem_rtrn_data_i = line_for(mem_last_addr);
        mem_rtrn_vld_i  = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // fetch drivers
  ////////////////////////////////////////////////////////////

  // hold one request until accepted and wait for valid
  task automatic fetch_one(addr_t addr);
    int start_req;
    @(negedge clk_i);
    req_i  = 1'b1;
    addr_i = addr;
    #10;
    while (!ready_o) begin
      @(negedge clk_i);
      #10;
    end
    start_req   = mem_req_count;
    last_lat    = 0;
    last_misses = 0;
    do begin
      @(negedge clk_i);
      req_i = 1'b0;
      #10;
      last_lat++;
      if (miss_o) last_misses++;
    end while (!valid_o);
    last_from_mem = mem_rtrn_vld_i;
    last_reqs     = mem_req_count - start_req;
    check_word(data_o, expected_word(addr), "fetched word");
  endtask

  // back-to-back words of a resident line at one per cycle
  task automatic stream_hits(addr_t base, int count);
    addr_t pend_q[$];
    logic  acc_prev;
    int    sent;
    int    start_req;
    int    guard;
    sent      = 0;
    acc_prev  = 1'b0;
    guard     = 0;
    start_req = mem_req_count;
    while ((sent < count || acc_prev) && guard < 4 * count + 4) begin
      @(negedge clk_i);
      req_i  = (sent < count);
      addr_i = base + addr_t'(4 * sent);
      #10;
      check_flag(valid_o, acc_prev, "hit valid one cycle after accept");
      if (valid_o && pend_q.size() > 0) begin
        check_word(data_o, expected_word(pend_q.pop_front()), "streamed hit word");
      end
      acc_prev = req_i & ready_o;
      if (acc_prev) begin
        pend_q.push_back(addr_i);
        sent++;
      end
      guard++;
    end
    if (sent < count) begin
      error_count++;
      $display("stream of hits stalled after %0d of %0d requests", sent, count);
    end
    check_flag(logic'(mem_req_count == start_req), 1'b1, "no memory request on hits");
  endtask

  task automatic fetch_uncached(addr_t addr);
    fetch_one(addr);
    check_addr(mem_last_addr, {addr[31:2], 2'b00}, "uncached address word aligned");
    check_flag(mem_last_nc, 1'b1, "uncached flag to memory");
    check_flag(logic'(last_misses == 0), 1'b1, "no miss pulse when uncached");
    check_flag(logic'(last_reqs == 1), 1'b1, "uncached fetch goes to memory");
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_flush_quiet();
    int cycles;
    #10;
    check_flag(busy_o, 1'b1, "busy after reset");
    check_flag(ready_o, 1'b0, "ready after reset");
    check_flag(mem_req_o, 1'b0, "mem_req after reset");
    cycles = 0;
    while (!ready_o && cycles <= `ICACHE_SETS + 2) begin
      check_flag(valid_o | miss_o | mem_req_o, 1'b0, "outputs quiet during flush");
      @(negedge clk_i);
      #10;
      cycles++;
    end
    check_flag(logic'(cycles <= `ICACHE_SETS + 2), 1'b1, "ready within the flush time");
    check_flag(busy_o, 1'b0, "busy once ready after flush");
  endtask

  task automatic cold_miss_refill();
    fetch_one(LINE_A + 4);
    check_addr(mem_last_addr, LINE_A, "refill address line aligned");
    check_flag(mem_last_nc, 1'b0, "refill is cacheable");
    check_flag(logic'(last_misses == 1), 1'b1, "one miss pulse");
    check_flag(logic'(last_reqs == 1), 1'b1, "one refill request");
    check_flag(last_from_mem, 1'b1, "valid in the return cycle");
  endtask

  task automatic resident_line_hits();
    fetch_one(LINE_A + 8);
    check_flag(logic'(last_lat == 1), 1'b1, "hit returns one cycle after accept");
    check_flag(logic'(last_reqs == 0), 1'b1, "no memory request on a hit");
    stream_hits(LINE_A, 4);
  endtask

  task automatic uncached_and_disabled();
    fetch_uncached(UNC_ADDR);
    fetch_uncached(UNC_ADDR);
    // disabled cache sends even a resident line to memory
    @(negedge clk_i);
    en_i = 1'b0;
    fetch_uncached(LINE_A + 4);
    fetch_uncached(LINE_A + 4);
    @(negedge clk_i);
    en_i = 1'b1;
  endtask

  task automatic flush_forces_miss();
    // enabling again flushed the arrays
    fetch_one(LINE_A + 12);
    check_flag(logic'(last_misses == 1), 1'b1, "miss after enable");
    fetch_one(LINE_A + 12);
    check_flag(logic'(last_reqs == 0), 1'b1, "line resident before flush");
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    fetch_one(LINE_A + 12);
    check_flag(logic'(last_misses == 1), 1'b1, "miss after flush");
  endtask

  // five tags into set 5 of a four way cache
  task automatic five_lines_one_set();
    addr_t       lines [5];
    logic [31:0] rnd;
    logic        dup;
    int          misses;
    for (int i = 0; i < 5; i++) begin
      do begin
        rnd      = next_rand();
        lines[i] = {1'b0, rnd[30:8], 4'h5, rnd[1:0], 2'b00};
        dup      = 1'b0;
        for (int j = 0; j < i; j++) begin
          if (lines[j][31:8] == lines[i][31:8]) dup = 1'b1;
        end
      end while (dup);
      fetch_one(lines[i]);
      check_flag(logic'(last_misses == 1), 1'b1, "new line misses");
    end
    misses = 0;
    for (int i = 0; i < 5; i++) begin
      fetch_one(lines[i]);
      misses += last_misses;
    end
    check_flag(logic'(misses >= 1), 1'b1, "reread after eviction misses");
  endtask

  ////////////////////////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin : main
    error_count = 0;
    lcg_state   = 32'h2ed4f284;
    rst_ni      = 1'b0;
    en_i        = 1'b1;
    flush_i     = 1'b0;
    req_i       = 1'b0;
    addr_i      = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    reset_flush_quiet();
    cold_miss_refill();
    resident_line_hits();
    uncached_and_disabled();
    flush_forces_miss();
    five_lines_one_set();
    repeat (2) @(negedge clk_i);
    $display("icache_tb finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+logic
logic/icache_pkg.sv
logic/icache_ctrl.sv
logic/icache_way_select.sv
logic/icache_arrays.sv
logic/icache_top.sv
dv/icache_tb.sv
